/* flist.f */
+incdir+common
common/capture_pkg.sv
design/acq_fifo.sv
scheduler/capture_scheduler.sv
design/buffer_memory.sv
design/tx_fifo.sv
design/capture_top.sv
testbench/capture_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the capture testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module capture_tb \
   -f flist.f -o capture_sim > sim.log 2>&1 \
   && ./obj_dir/capture_sim >> sim.log 2>&1 \
   || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

/* testbench/capture_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module capture_tb;

   localparam int FILL_WORDS  = `CAP_FILL_THRESHOLD;
   localparam int BURST_WORDS = `CAP_TX_HIGH + 1;   // held in tx FIFO when tx_ready_first rises
   localparam int TAIL_CYCLES = 40;
   // fill plus drain at about five cycles per word on each side
   localparam int RUN_CYCLES      = 2 * FILL_WORDS * 5;
   localparam int WATCHDOG_CYCLES = 31 * RUN_CYCLES;

   logic                       write_clk;
   logic                       rst;
   logic                       start_req;
   logic                       sample_valid;
   logic [`CAP_DATA_WIDTH-1:0] sample_data;
   logic                       tx_read;
   logic                       acq_armed;
   logic                       buffer_filled;
   logic                       tx_ready_first;
   logic                       capture_done;
   logic                       tx_empty;
   logic [`CAP_DATA_WIDTH-1:0] tx_data;

   logic [`CAP_DATA_WIDTH-1:0] model_q [$];   // accepted samples in order
   int error_cnt        = 0;
   int edge_cnt         = 0;
   int first_start_edge = -1;
   int written_cnt      = 0;
   int pop_cnt          = 0;
   int read_cnt         = 0;
   logic out_of_reset   = 1'b0;
   logic armed_at_fall  = 1'b0;
   logic empty_at_fall  = 1'b1;

   capture_top uut
   (
      .write_clk      (write_clk),
      .rst            (rst),
      .start_req      (start_req),
      .sample_valid   (sample_valid),
      .sample_data    (sample_data),
      .acq_armed      (acq_armed),
      .buffer_filled  (buffer_filled),
      .tx_ready_first (tx_ready_first),
      .capture_done   (capture_done),
      .tx_empty       (tx_empty),
      .tx_data        (tx_data),
      .tx_read        (tx_read)
   );

   initial
   begin
      write_clk = 1'b0;
      forever #4 write_clk = ~write_clk;
   end

   task automatic report_bit_mismatch(input string name, input logic got, input logic exp);
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
      error_cnt++;
   endtask

   task automatic report_word_mismatch(input string name, input logic [`CAP_DATA_WIDTH-1:0] got,
                                       input logic [`CAP_DATA_WIDTH-1:0] exp);
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      error_cnt++;
   endtask

   task automatic report_failure(input string msg);
      $display("ERROR t=%0t %s", $time, msg);
      error_cnt++;
   endtask

   task automatic check_idle_outputs();
      if (acq_armed !== 1'b0)
         report_bit_mismatch("acq_armed", acq_armed, 1'b0);
      if (buffer_filled !== 1'b0)
         report_bit_mismatch("buffer_filled", buffer_filled, 1'b0);
      if (tx_ready_first !== 1'b0)
         report_bit_mismatch("tx_ready_first", tx_ready_first, 1'b0);
      if (capture_done !== 1'b0)
         report_bit_mismatch("capture_done", capture_done, 1'b0);
   endtask

   // offered every cycle until armed, then about one sample in three
   // and held off while the FIFO is full
   task automatic drive_samples();
      int accepted;
      accepted = 0;
      repeat ($urandom_range(2, 12))
      begin
         @(negedge write_clk);
         sample_valid = 1'b1;   // before start, must be ignored
         sample_data  = 16'($urandom);
      end
      start_req = 1'b1;
      while (accepted < FILL_WORDS)
      begin
         @(negedge write_clk);
         sample_data = 16'($urandom);
         if (!acq_armed)
            sample_valid = 1'b1;   // not armed yet, never enters the model
         else if ((uut.acq_status_cnt != `CAP_ACQ_DEPTH) && ($urandom_range(0, 2) == 0))
         begin
            sample_valid = 1'b1;
            model_q.push_back(sample_data);
            accepted++;
         end
         else
            sample_valid = 1'b0;
      end
      @(negedge write_clk);
      sample_valid = 1'b0;
   endtask

   task automatic pop_head();
      logic [`CAP_DATA_WIDTH-1:0] expected;
      if (model_q.size() == 0)
         report_failure("tx FIFO offered a word with no sample left in the model");
      else
      begin
         expected = model_q.pop_front();
         if (tx_data !== expected)
            report_word_mismatch("tx_data", tx_data, expected);
      end
      tx_read = 1'b1;
      read_cnt++;
   endtask

   task automatic read_back();
      @(negedge write_clk);
      while (!tx_ready_first)
         @(negedge write_clk);
      for (int i = 0; i < BURST_WORDS; i++)
      begin
         if (tx_empty)
         begin
            report_failure("tx_empty went high during the first back-to-back burst");
            tx_read = 1'b0;
         end
         else
            pop_head();
         @(negedge write_clk);
      end
      while (read_cnt < FILL_WORDS)
      begin
         if (!tx_empty && ($urandom_range(0, 1) == 1))
            pop_head();
         else
            tx_read = 1'b0;
         @(negedge write_clk);
      end
      tx_read = 1'b0;
   endtask

   // inputs are stable here, driven on the falling edge
   always @(posedge write_clk)
   begin
      edge_cnt     = edge_cnt + 1;
      out_of_reset = !rst;
      if (start_req && (first_start_edge < 0))
         first_start_edge = edge_cnt;
      if (sample_valid && armed_at_fall)
         written_cnt = written_cnt + 1;
      if (tx_read && !empty_at_fall)
         pop_cnt = pop_cnt + 1;
   end

   always @(negedge write_clk)
   begin
      armed_at_fall = acq_armed;
      empty_at_fall = tx_empty;
      if (out_of_reset)
      begin
         if (acq_armed && ((first_start_edge < 0) || (edge_cnt < first_start_edge + 2)))
            report_failure("acq_armed rose less than two edges after start_req was sampled");
         if (buffer_filled && (written_cnt < FILL_WORDS))
            report_failure("buffer_filled rose before all samples were accepted");
         if (capture_done && tx_empty && (pop_cnt < FILL_WORDS))
            report_failure("capture_done high but not all words were produced");
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge write_clk);
      $display("timeout after %0d cycles, capture never completed", WATCHDOG_CYCLES);
      $display("errors: %0d", error_cnt);
      $display("sim failed");
      $finish;
   end

   initial
   begin
      rst          = 1'b1;
      start_req    = 1'b0;
      sample_valid = 1'b0;
      sample_data  = '0;
      tx_read      = 1'b0;
      void'($urandom(49050));
      repeat (5)
      begin
         @(negedge write_clk);
         check_idle_outputs();
      end
      rst = 1'b0;
      @(negedge write_clk);
      check_idle_outputs();   // right after release
      fork
         drive_samples();
         read_back();
      join
      while (!capture_done)
         @(negedge write_clk);
      repeat (TAIL_CYCLES)
      begin
         @(negedge write_clk);
         if (!tx_empty)
            report_failure("an extra word appeared after all words were read");
         if (capture_done !== 1'b1)
            report_bit_mismatch("capture_done", capture_done, 1'b1);
      end
      if (buffer_filled !== 1'b1)
         report_bit_mismatch("buffer_filled", buffer_filled, 1'b1);
      if (tx_ready_first !== 1'b1)
         report_bit_mismatch("tx_ready_first", tx_ready_first, 1'b1);
      if (model_q.size() != 0)
         report_failure("samples left in the model that never came out");
      $display("errors: %0d", error_cnt);
      if (error_cnt == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

/* design/capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module capture_top
   import capture_pkg::*;
(
   input  logic                       write_clk,
   input  logic                       rst,
   input  logic                       start_req,
   input  logic                       sample_valid,
   input  logic [`CAP_DATA_WIDTH-1:0] sample_data,
   output logic                       acq_armed,
   output logic                       buffer_filled,
   output logic                       tx_ready_first,
   output logic                       capture_done,
   output logic                       tx_empty,
   output logic [`CAP_DATA_WIDTH-1:0] tx_data,
   input  logic                       tx_read
);

   logic                           acq_wr_en;
   logic                           acq_read_en;
   logic [`CAP_DATA_WIDTH-1:0]     acq_dout;
   logic [`CAP_FIFO_CNT_WIDTH-1:0] acq_status_cnt;
   logic                           cmd_ready;
   logic                           cmd_enable;
   mem_cmd_t                       cmd;
   logic [`CAP_DATA_WIDTH-1:0]     rd_data;
   logic                           rd_valid;
   logic [`CAP_FIFO_CNT_WIDTH-1:0] tx_status_cnt;

   assign acq_wr_en = sample_valid & acq_armed;   // nothing is captured before start

   acq_fifo u_acq_fifo
   (
      .write_clk  (write_clk),
      .rst        (rst),
      .wr_en      (acq_wr_en),
      .wr_data    (sample_data),
      .rd_en      (acq_read_en),
      .rd_data    (acq_dout),
      .status_cnt (acq_status_cnt)
   );

   capture_scheduler u_scheduler
   (
      .write_clk      (write_clk),
      .rst            (rst),
      .start_req      (start_req),
      .acq_status_cnt (acq_status_cnt),
      .acq_armed      (acq_armed),
      .acq_read_en    (acq_read_en),
      .acq_dout       (acq_dout),
      .cmd_ready      (cmd_ready),
      .cmd_enable     (cmd_enable),
      .cmd            (cmd),
      .tx_status_cnt  (tx_status_cnt),
      .buffer_filled  (buffer_filled),
      .tx_ready_first (tx_ready_first),
      .capture_done   (capture_done)
   );

   buffer_memory u_buffer_memory
   (
      .write_clk  (write_clk),
      .rst        (rst),
      .cmd_enable (cmd_enable),
      .cmd        (cmd),
      .cmd_ready  (cmd_ready),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid)
   );

   // read data lands straight in the transmit FIFO
   tx_fifo u_tx_fifo
   (
      .write_clk  (write_clk),
      .rst        (rst),
      .wr_en      (rd_valid),
      .wr_data    (rd_data),
      .rd_en      (tx_read),
      .rd_data    (tx_data),
      .empty      (tx_empty),
      .status_cnt (tx_status_cnt)
   );

endmodule

`default_nettype wire

/* design/tx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module tx_fifo
(
   input  logic                           write_clk,
   input  logic                           rst,
   input  logic                           wr_en,
   input  logic [`CAP_DATA_WIDTH-1:0]     wr_data,
   input  logic                           rd_en,
   output logic [`CAP_DATA_WIDTH-1:0]     rd_data,
   output logic                           empty,
   output logic [`CAP_FIFO_CNT_WIDTH-1:0] status_cnt
);

   localparam int PTR_W = $clog2(`CAP_TX_DEPTH);

   logic [`CAP_DATA_WIDTH-1:0] mem [0:`CAP_TX_DEPTH-1];
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   logic                       do_wr;
   logic                       do_rd;

   assign empty   = (status_cnt == '0);
   assign rd_data = mem[rd_ptr];   // head word, valid while not empty
   assign do_wr   = wr_en & (status_cnt != `CAP_TX_DEPTH);
   assign do_rd   = rd_en & ~empty;

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         status_cnt <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   status_cnt <= status_cnt + 1'b1;
            2'b01:   status_cnt <= status_cnt - 1'b1;
            default: status_cnt <= status_cnt;
         endcase
      end
   end

   always_ff @(posedge write_clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

endmodule

`default_nettype wire

/* design/buffer_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module buffer_memory
   import capture_pkg::*;
(
   input  logic                       write_clk,
   input  logic                       rst,
   input  logic                       cmd_enable,
   input  mem_cmd_t                   cmd,
   output logic                       cmd_ready,
   output logic [`CAP_DATA_WIDTH-1:0] rd_data,
   output logic                       rd_valid
);

   localparam int WORDS  = 2 ** `CAP_ADDR_WIDTH;
   localparam int BUSY_W = $clog2(`CAP_MEM_BUSY + 1);

   logic [`CAP_DATA_WIDTH-1:0] mem [0:WORDS-1];
   logic [BUSY_W-1:0]          busy_cnt;
   logic                       accept;
   logic                       rd_pend;    // first read stage
   logic [`CAP_ADDR_WIDTH-1:0] rd_addr;

   assign cmd_ready = (busy_cnt == '0);
   assign accept    = cmd_enable & cmd_ready;

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         busy_cnt <= '0;
         rd_pend  <= 1'b0;
         rd_valid <= 1'b0;
      end
      else
      begin
         if (accept)
            busy_cnt <= BUSY_W'(`CAP_MEM_BUSY);
         else if (busy_cnt != '0)
            busy_cnt <= busy_cnt - 1'b1;
         rd_pend  <= accept & ~cmd.wr;
         rd_valid <= rd_pend;   // one cycle per read
      end
   end

   always_ff @(posedge write_clk)
   begin
      if (accept && cmd.wr)
         mem[cmd.address] <= cmd.wdata;
      if (accept)
         rd_addr <= cmd.address;
      if (rd_pend)
         rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* scheduler/capture_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module capture_scheduler
   import capture_pkg::*;
(
   input  logic                           write_clk,
   input  logic                           rst,
   input  logic                           start_req,
   input  logic [`CAP_FIFO_CNT_WIDTH-1:0] acq_status_cnt,
   output logic                           acq_armed,
   output logic                           acq_read_en,
   input  logic [`CAP_DATA_WIDTH-1:0]     acq_dout,
   input  logic                           cmd_ready,
   output logic                           cmd_enable,
   output mem_cmd_t                       cmd,
   input  logic [`CAP_FIFO_CNT_WIDTH-1:0] tx_status_cnt,
   output logic                           buffer_filled,
   output logic                           tx_ready_first,
   output logic                           capture_done
);

   localparam int BLK_W = $clog2(`CAP_BLOCKSIZE) + 1;

   logic [1:0]                start_sync;
   sched_state_t              state;
   logic [BLK_W-1:0]          blk_cnt;
   logic [`CAP_ADDR_WIDTH-1:0] wr_ptr;
   logic [`CAP_ADDR_WIDTH-1:0] rd_ptr;
   logic                      issue_slot;
   logic                      issue_wr;
   logic                      issue_rd;
   logic                      drain_done;

   // start_req comes from outside the clock domain
   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         start_sync <= 2'b00;
         acq_armed  <= 1'b0;
      end
      else
      begin
         start_sync <= {start_sync[0], start_req};
         if (start_sync[1])
            acq_armed <= 1'b1;   // sticky until reset
      end
   end

   // a command may go out only when the memory is idle and the last strobe has dropped
   assign issue_slot = cmd_ready & ~cmd_enable;
   // acq_read_en high means the pop is still in progress, acq_dout not valid yet
   assign issue_wr   = (state == AQ_FIFO_TO_MEM) & ~acq_read_en & issue_slot;
   assign issue_rd   = (state == TX_FILLING) & (tx_status_cnt <= `CAP_TX_HIGH) &
                       (rd_ptr < `CAP_FILL_THRESHOLD) & issue_slot;
   // memory idle again, so the last read has already landed in the tx FIFO
   assign drain_done = (rd_ptr >= `CAP_FILL_THRESHOLD) & issue_slot;

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         state          <= AQ_WAITING;
         blk_cnt        <= '0;
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         acq_read_en    <= 1'b0;
         cmd_enable     <= 1'b0;
         buffer_filled  <= 1'b0;
         tx_ready_first <= 1'b0;
         capture_done   <= 1'b0;
      end
      else
      begin
         acq_read_en <= 1'b0;   // both are one-cycle strobes
         cmd_enable  <= 1'b0;
         case (state)
            AQ_WAITING:
            begin
               if (wr_ptr >= `CAP_FILL_THRESHOLD)
               begin
                  buffer_filled <= 1'b1;
                  state         <= TX_FILLING;
               end
               else if (acq_status_cnt >= `CAP_BLOCKSIZE)
               begin
                  blk_cnt <= '0;
                  state   <= AQ_READ_ONE;
               end
            end
            AQ_READ_ONE:
            begin
               if (blk_cnt == `CAP_BLOCKSIZE)
                  state <= AQ_WAITING;   // burst complete
               else
               begin
                  blk_cnt     <= blk_cnt + 1'b1;
                  acq_read_en <= 1'b1;
                  state       <= AQ_FIFO_TO_MEM;
               end
            end
            AQ_FIFO_TO_MEM:
            begin
               if (issue_wr)
               begin
                  cmd_enable <= 1'b1;
                  wr_ptr     <= wr_ptr + 1'b1;
                  state      <= AQ_READ_ONE;
               end
            end
            TX_FILLING:
            begin
               if (tx_status_cnt > `CAP_TX_HIGH)
               begin
                  tx_ready_first <= 1'b1;
                  state          <= TX_IDLE;
               end
               else if (drain_done)
               begin
                  capture_done <= 1'b1;
                  state        <= FINISHED;
               end
               else if (issue_rd)
               begin
                  cmd_enable <= 1'b1;
                  rd_ptr     <= rd_ptr + 1'b1;
               end
            end
            TX_IDLE:
            begin
               if (drain_done)
               begin
                  capture_done <= 1'b1;
                  state        <= FINISHED;
               end
               else if ((rd_ptr < `CAP_FILL_THRESHOLD) && (tx_status_cnt < `CAP_TX_LOW))
                  state <= TX_FILLING;
            end
            FINISHED:
               state <= FINISHED;   // one-shot, only reset leaves
            default:
               state <= AQ_WAITING;
         endcase
      end
   end

   // command payload, qualified by cmd_enable
   always_ff @(posedge write_clk)
   begin
      if (issue_wr)
      begin
         cmd.wr      <= 1'b1;
         cmd.address <= wr_ptr;
         cmd.wdata   <= acq_dout;
      end
      else if (issue_rd)
      begin
         cmd.wr      <= 1'b0;
         cmd.address <= rd_ptr;
         cmd.wdata   <= '0;
      end
   end

endmodule

`default_nettype wire

/* design/acq_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module acq_fifo
(
   input  logic                           write_clk,
   input  logic                           rst,
   input  logic                           wr_en,
   input  logic [`CAP_DATA_WIDTH-1:0]     wr_data,
   input  logic                           rd_en,
   output logic [`CAP_DATA_WIDTH-1:0]     rd_data,
   output logic [`CAP_FIFO_CNT_WIDTH-1:0] status_cnt
);

   localparam int PTR_W = $clog2(`CAP_ACQ_DEPTH);

   logic [`CAP_DATA_WIDTH-1:0] mem [0:`CAP_ACQ_DEPTH-1];
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   logic                       full;
   logic                       empty;
   logic                       do_wr;
   logic                       do_rd;

   assign full  = (status_cnt == `CAP_ACQ_DEPTH);
   assign empty = (status_cnt == '0);
   assign do_wr = wr_en & ~full;   // samples offered when full are lost
   assign do_rd = rd_en & ~empty;

   always_ff @(posedge write_clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         status_cnt <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   status_cnt <= status_cnt + 1'b1;
            2'b01:   status_cnt <= status_cnt - 1'b1;
            default: status_cnt <= status_cnt;
         endcase
      end
   end

   // storage and output register
   always_ff @(posedge write_clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
      if (do_rd)
         rd_data <= mem[rd_ptr];   // held until the next pop
   end

endmodule

`default_nettype wire

/* common/capture_pkg.sv */
`default_nettype none

`include "capture_defs.svh"

package capture_pkg;

   typedef enum logic [2:0]
   {
      AQ_WAITING,
      AQ_READ_ONE,
      AQ_FIFO_TO_MEM,
      TX_FILLING,
      TX_IDLE,
      FINISHED
   } sched_state_t;

   // one command on the memory port
   typedef struct packed
   {
      logic                       wr;       // 1 = write, 0 = read
      logic [`CAP_ADDR_WIDTH-1:0] address;
      logic [`CAP_DATA_WIDTH-1:0] wdata;
   } mem_cmd_t;

endpackage

`default_nettype wire

/* common/capture_defs.svh */
`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// sample word and buffer memory geometry
`define CAP_DATA_WIDTH      16
`define CAP_ADDR_WIDTH      7

// words moved per acquisition burst
`define CAP_BLOCKSIZE       8
// words stored before readback, also the total output
`define CAP_FILL_THRESHOLD  64

`define CAP_ACQ_DEPTH       32
`define CAP_TX_DEPTH        32
`define CAP_FIFO_CNT_WIDTH  6   // holds 0..depth

// transmit watermarks
`define CAP_TX_HIGH         15
`define CAP_TX_LOW          5

// cycles cmd_ready stays low after an accepted command
`define CAP_MEM_BUSY        3

`endif
